//--- rtl/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// cache geometry, 2 ways x 256 sets x 16-byte lines
`define CACHE_WAYS   2
`define CACHE_SETS   256
`define CACHE_BANKS  4      // words per line, one RAM bank each

// address split {tag, index, offset}
`define TAG_W        20
`define INDEX_W      8
`define OFFSET_W     4

`define WORD_W       32

`endif

//--- rtl/cache_types_pkg.sv
`include "cache_defines.svh"

package cache_types_pkg;

    // address fields
    typedef logic [`TAG_W-1:0]    tag_t;
    typedef logic [`INDEX_W-1:0]  index_t;
    typedef logic [`OFFSET_W-1:0] offset_t;

    // data widths
    typedef logic [`WORD_W-1:0]              word_t;
    typedef logic [`WORD_W/8-1:0]            strb_t;
    typedef logic [`CACHE_BANKS*`WORD_W-1:0] line_t;
    typedef logic [`TAG_W:0]                 tagv_t;  // {tag, valid}

endpackage

//--- rtl/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

    // main FSM, one-hot
    typedef enum logic [4:0] {
        idle    = 5'b00001,
        lookup  = 5'b00010,
        miss    = 5'b00100,
        replace = 5'b01000,
        refill  = 5'b10000
    } main_state_t;

    typedef enum logic [1:0] {
        wb_idle  = 2'b01,
        wb_write = 2'b10
    } wb_state_t;

    // rd_type / wr_type codes on the memory side
    typedef enum logic [2:0] {
        mem_byte = 3'b000,
        mem_half = 3'b001,
        mem_word = 3'b010,
        mem_line = 3'b100
    } mem_type_t;

endpackage

//--- rtl/sram_sp.sv
`timescale 1ns/10ps

module sram_sp #(
    parameter int DATA_W = 32,
    parameter int DEPTH  = 256
) (
    input  logic                       clk,
    input  logic [(DATA_W+7)/8-1:0]    we,     // one enable per byte lane
    input  logic [$clog2(DEPTH)-1:0]   addr,
    input  logic [DATA_W-1:0]          wdata,
    output logic [DATA_W-1:0]          rdata
);

    logic [DATA_W-1:0] mem [DEPTH];

    // read-first, output registered
    always_ff @(posedge clk) begin
        for (int i = 0; i < DATA_W; i++) begin
            if (we[i/8]) begin
                mem[addr][i] <= wdata[i];
            end
        end
        rdata <= mem[addr];
    end

endmodule

//--- rtl/cache_ram_if.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

interface cache_ram_if;

    // controller side
    cache_types_pkg::index_t                                    rd_index;   // tag read/write set
    logic [`CACHE_WAYS-1:0]                                     tagv_we;
    cache_types_pkg::tagv_t                                     tagv_wdata;
    cache_types_pkg::strb_t [`CACHE_WAYS-1:0][`CACHE_BANKS-1:0] bank_we;
    cache_types_pkg::index_t [`CACHE_BANKS-1:0]                 bank_addr;
    cache_types_pkg::word_t [`CACHE_BANKS-1:0]                  bank_wdata;
    cache_types_pkg::tag_t                                      cmp_tag;
    logic [1:0]                                                 cmp_bank;   // word of the line
    logic                                                       victim_way;

    // storage side
    logic [`CACHE_WAYS-1:0]                                     hit_way;
    cache_types_pkg::word_t                                     hit_word;
    cache_types_pkg::tagv_t                                     victim_tagv;
    cache_types_pkg::line_t                                     victim_line;

    modport ctrl (
        output rd_index, tagv_we, tagv_wdata, bank_we, bank_addr, bank_wdata,
        output cmp_tag, cmp_bank, victim_way,
        input  hit_way, hit_word, victim_tagv, victim_line
    );

    modport store (
        input  rd_index, tagv_we, tagv_wdata, bank_we, bank_addr, bank_wdata,
        input  cmp_tag, cmp_bank, victim_way,
        output hit_way, hit_word, victim_tagv, victim_line
    );

endinterface

//--- rtl/cache_store.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_store (
    input  logic        clk,
    cache_ram_if.store  ram
);

    localparam int TAGV_W  = $bits(cache_types_pkg::tagv_t);
    localparam int TAGV_NB = (TAGV_W + 7) / 8;

    cache_types_pkg::tagv_t tagv_rdata [`CACHE_WAYS];
    cache_types_pkg::word_t bank_rdata [`CACHE_WAYS][`CACHE_BANKS];
    cache_types_pkg::word_t way_word   [`CACHE_WAYS];

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        // single tag enable spread across all byte lanes
        sram_sp #(
            .DATA_W (TAGV_W),
            .DEPTH  (`CACHE_SETS)
        ) u_tagv (
            .clk   (clk),
            .we    ({TAGV_NB{ram.tagv_we[w]}}),
            .addr  (ram.rd_index),
            .wdata (ram.tagv_wdata),
            .rdata (tagv_rdata[w])
        );

        for (genvar b = 0; b < `CACHE_BANKS; b++) begin : g_bank
            sram_sp #(
                .DATA_W (`WORD_W),
                .DEPTH  (`CACHE_SETS)
            ) u_bank (
                .clk   (clk),
                .we    (ram.bank_we[w][b]),
                .addr  (ram.bank_addr[b]),
                .wdata (ram.bank_wdata[b]),
                .rdata (bank_rdata[w][b])
            );
        end

        assign ram.hit_way[w] = tagv_rdata[w][0] & (tagv_rdata[w][`TAG_W:1] == ram.cmp_tag);
        assign way_word[w]    = {`WORD_W{ram.hit_way[w]}} & bank_rdata[w][ram.cmp_bank];
    end

    // at most one way hits, so an OR is enough
    always_comb begin
        ram.hit_word = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            ram.hit_word = ram.hit_word | way_word[w];
        end
    end

    // victim read-out for write-back, bank 0 in the low word
    always_comb begin
        ram.victim_tagv = tagv_rdata[ram.victim_way];
        for (int b = 0; b < `CACHE_BANKS; b++) begin
            ram.victim_line[b*`WORD_W +: `WORD_W] = bank_rdata[ram.victim_way][b];
        end
    end

endmodule

//--- rtl/cache_ctrl.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_ctrl (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       valid,
    input  logic                       op,          // 1 write, 0 read
    input  logic                       cacheable,
    input  cache_types_pkg::index_t    index,
    input  cache_types_pkg::tag_t      tag,
    input  cache_types_pkg::offset_t   offset,
    input  cache_types_pkg::strb_t     wstrb,
    input  cache_types_pkg::word_t     wdata,
    output logic                       addr_ok,
    output logic                       data_ok,
    output cache_types_pkg::word_t     rdata,
    output logic                       rd_req,
    output cache_ctrl_pkg::mem_type_t  rd_type,
    output logic [31:0]                rd_addr,
    input  logic                       rd_rdy,
    input  logic                       ret_valid,
    input  logic                       ret_last,
    input  cache_types_pkg::word_t     ret_data,
    output logic                       wr_req,
    output cache_ctrl_pkg::mem_type_t  wr_type,
    output logic [31:0]                wr_addr,
    output cache_types_pkg::strb_t     wr_wstrb,
    output cache_types_pkg::line_t     wr_data,
    input  logic                       wr_rdy,
    cache_ram_if.ctrl                  ram
);

    cache_ctrl_pkg::main_state_t state, state_nxt;
    cache_ctrl_pkg::wb_state_t   wb_state, wb_state_nxt;

    // request buffer
    logic                      op_r;
    logic                      cacheable_r;
    cache_types_pkg::index_t   index_r;
    cache_types_pkg::tag_t     tag_r;
    cache_types_pkg::offset_t  offset_r;
    cache_types_pkg::strb_t    wstrb_r;
    cache_types_pkg::word_t    wdata_r;

    // write buffer
    logic                      wrbuf_way;
    cache_types_pkg::index_t   wrbuf_index;
    logic [1:0]                wrbuf_bank;
    cache_types_pkg::strb_t    wrbuf_wstrb;
    cache_types_pkg::word_t    wrbuf_wdata;
    logic                      wb_was_write;   // bank outputs stale this cycle

    logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] dirty;
    logic [`CACHE_SETS-1:0]                  repl_bit;
    logic [1:0]                              ret_cnt;

    logic in_idle, in_lookup, in_miss, in_refill, wb_busy;
    logic cache_hit, hit_write, rd_conflict, accept;
    logic victim_way, victim_dirty, wr_fire, refill_beat, refill_done;
    cache_types_pkg::index_t look_index;
    cache_types_pkg::word_t  refill_word;

    assign in_idle   = (state == cache_ctrl_pkg::idle);
    assign in_lookup = (state == cache_ctrl_pkg::lookup);
    assign in_miss   = (state == cache_ctrl_pkg::miss);
    assign in_refill = (state == cache_ctrl_pkg::refill);
    assign wb_busy   = (wb_state == cache_ctrl_pkg::wb_write);

    assign cache_hit = cacheable_r & (|ram.hit_way);   // uncached never hits
    assign hit_write = in_lookup & cache_hit & op_r;

    // a read may not sample a bank that the write buffer owns or is about to own
    assign rd_conflict = valid & ~op &
        ((wb_busy & (offset[3:2] == wrbuf_bank)) |
         (hit_write & ({tag, index, offset[3:2]} == {tag_r, index_r, offset_r[3:2]})));

    assign addr_ok = ~rd_conflict & (in_idle | (in_lookup & cache_hit));
    assign accept  = valid & addr_ok;

    assign victim_way   = repl_bit[index_r];
    assign victim_dirty = ram.victim_tagv[0] & dirty[victim_way][index_r];
    assign wr_fire      = in_miss & wr_rdy & ~wb_was_write;
    assign refill_beat  = in_refill & ret_valid;
    assign refill_done  = refill_beat & ret_last;

    always_comb begin
        state_nxt = state;
        case (state)
            cache_ctrl_pkg::idle: begin
                if (accept) begin
                    state_nxt = cache_ctrl_pkg::lookup;
                end
            end
            cache_ctrl_pkg::lookup: begin
                if (cache_hit) begin
                    state_nxt = accept ? cache_ctrl_pkg::lookup : cache_ctrl_pkg::idle;
                end else if (!cacheable_r) begin
                    state_nxt = op_r ? cache_ctrl_pkg::miss : cache_ctrl_pkg::replace;
                end else if (victim_dirty) begin
                    state_nxt = cache_ctrl_pkg::miss;
                end else begin
                    state_nxt = cache_ctrl_pkg::replace;
                end
            end
            cache_ctrl_pkg::miss: begin
                if (wr_fire) begin
                    state_nxt = cacheable_r ? cache_ctrl_pkg::replace : cache_ctrl_pkg::idle;
                end
            end
            cache_ctrl_pkg::replace: begin
                if (rd_rdy) begin
                    state_nxt = cache_ctrl_pkg::refill;
                end
            end
            cache_ctrl_pkg::refill: begin
                if (refill_done) begin
                    state_nxt = cache_ctrl_pkg::idle;
                end
            end
            default: state_nxt = cache_ctrl_pkg::idle;
        endcase
    end

    always_comb begin
        case (wb_state)
            cache_ctrl_pkg::wb_idle:  wb_state_nxt = hit_write ? cache_ctrl_pkg::wb_write
                                                               : cache_ctrl_pkg::wb_idle;
            cache_ctrl_pkg::wb_write: wb_state_nxt = hit_write ? cache_ctrl_pkg::wb_write
                                                               : cache_ctrl_pkg::wb_idle;
            default:                  wb_state_nxt = cache_ctrl_pkg::wb_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state        <= cache_ctrl_pkg::idle;
            wb_state     <= cache_ctrl_pkg::wb_idle;
            wb_was_write <= 1'b0;
            dirty        <= '0;
            repl_bit     <= '0;
            ret_cnt      <= 2'd0;
        end else begin
            state        <= state_nxt;
            wb_state     <= wb_state_nxt;
            wb_was_write <= wb_busy;
            if (hit_write) begin
                dirty[ram.hit_way[1]][index_r] <= 1'b1;   // marked now so a following miss sees it
            end else if (refill_done & cacheable_r) begin
                dirty[victim_way][index_r] <= op_r;
            end
            if (in_lookup & cache_hit) begin
                repl_bit[index_r] <= ram.hit_way[0];      // point at the other way
            end else if (refill_done & cacheable_r) begin
                repl_bit[index_r] <= ~repl_bit[index_r];
            end
            if (refill_beat) begin
                ret_cnt <= ret_last ? 2'd0 : ret_cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            {op_r, cacheable_r, index_r, tag_r} <= {op, cacheable, index, tag};
            {offset_r, wstrb_r, wdata_r}        <= {offset, wstrb, wdata};
        end
        if (hit_write) begin
            wrbuf_way   <= ram.hit_way[1];
            wrbuf_index <= index_r;
            wrbuf_bank  <= offset_r[3:2];
            wrbuf_wstrb <= wstrb_r;
            wrbuf_wdata <= wdata_r;
        end
    end

    // store bytes override the returned word
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            refill_word[8*k +: 8] = (op_r & wstrb_r[k]) ? wdata_r[8*k +: 8] : ret_data[8*k +: 8];
        end
    end

    assign look_index     = accept ? index : index_r;
    assign ram.rd_index   = look_index;
    assign ram.tagv_wdata = {tag_r, 1'b1};
    assign ram.cmp_tag    = tag_r;
    assign ram.cmp_bank   = offset_r[3:2];
    assign ram.victim_way = victim_way;

    for (genvar b = 0; b < `CACHE_BANKS; b++) begin : g_bank
        logic wb_here;   // write buffer owns this bank
        assign wb_here = wb_busy & (wrbuf_bank == 2'(b));
        assign ram.bank_addr[b]  = wb_here ? wrbuf_index : look_index;
        assign ram.bank_wdata[b] = wb_here ? wrbuf_wdata :
                                   (offset_r[3:2] == 2'(b)) ? refill_word : ret_data;
        for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
            assign ram.bank_we[w][b] =
                ({4{wb_here & (wrbuf_way == 1'(w))}} & wrbuf_wstrb) |
                {4{refill_beat & cacheable_r & (victim_way == 1'(w)) & (ret_cnt == 2'(b))}};
        end
    end

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_tag
        assign ram.tagv_we[w] = refill_done & cacheable_r & (victim_way == 1'(w));
    end

    // CPU side
    assign data_ok = (in_lookup & (cache_hit | (op_r & cacheable_r))) |
                     (wr_fire & ~cacheable_r) |
                     (refill_beat & ~op_r & (~cacheable_r | (ret_cnt == offset_r[3:2])));
    assign rdata   = in_refill ? ret_data : ram.hit_word;

    // memory side
    assign rd_req   = (state == cache_ctrl_pkg::replace);
    assign rd_type  = cacheable_r ? cache_ctrl_pkg::mem_line : cache_ctrl_pkg::mem_word;
    assign rd_addr  = cacheable_r ? {tag_r, index_r, 4'b0000}
                                  : {tag_r, index_r, offset_r[3:2], 2'b00};

    assign wr_req   = wr_fire;
    assign wr_type  = cacheable_r ? cache_ctrl_pkg::mem_line : cache_ctrl_pkg::mem_word;
    assign wr_addr  = cacheable_r ? {ram.victim_tagv[`TAG_W:1], index_r, 4'b0000}
                                  : {tag_r, index_r, offset_r[3:2], 2'b00};
    assign wr_wstrb = cacheable_r ? 4'hf : wstrb_r;
    assign wr_data  = cacheable_r ? ram.victim_line : {96'd0, wdata_r};

endmodule

//--- rtl/cache_top.sv
`timescale 1ns/10ps

module cache_top (
    input  logic                       clk,
    input  logic                       resetn,
    // CPU request port
    input  logic                       valid,
    input  logic                       op,
    input  logic                       cacheable,
    input  cache_types_pkg::index_t    index,
    input  cache_types_pkg::tag_t      tag,
    input  cache_types_pkg::offset_t   offset,
    input  cache_types_pkg::strb_t     wstrb,
    input  cache_types_pkg::word_t     wdata,
    output logic                       addr_ok,
    output logic                       data_ok,
    output cache_types_pkg::word_t     rdata,
    // memory read side
    output logic                       rd_req,
    output cache_ctrl_pkg::mem_type_t  rd_type,
    output logic [31:0]                rd_addr,
    input  logic                       rd_rdy,
    input  logic                       ret_valid,
    input  logic                       ret_last,
    input  cache_types_pkg::word_t     ret_data,
    // memory write side
    output logic                       wr_req,
    output cache_ctrl_pkg::mem_type_t  wr_type,
    output logic [31:0]                wr_addr,
    output cache_types_pkg::strb_t     wr_wstrb,
    output cache_types_pkg::line_t     wr_data,
    input  logic                       wr_rdy
);

    cache_ram_if ram ();

    cache_ctrl u_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .cacheable (cacheable),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_type   (rd_type),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_type   (wr_type),
        .wr_addr   (wr_addr),
        .wr_wstrb  (wr_wstrb),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .ram       (ram.ctrl)
    );

    // tag and data arrays
    cache_store u_store (
        .clk (clk),
        .ram (ram.store)
    );

endmodule

//--- verif/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    initial begin
        resetn = 1'b0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

//--- verif/cache_tb.sv
`timescale 1ns/10ps

module cache_tb;

    localparam int NROWS   = 19;
    localparam int TIMEOUT = 200;   // cycles per wait

    logic clk, resetn;
    logic valid, op, cacheable;
    cache_types_pkg::index_t   index;
    cache_types_pkg::tag_t     tag;
    cache_types_pkg::offset_t  offset;
    cache_types_pkg::strb_t    wstrb, wr_wstrb;
    cache_types_pkg::word_t    wdata, rdata, ret_data;
    logic addr_ok, data_ok, rd_req, rd_rdy, ret_valid, ret_last, wr_req, wr_rdy;
    cache_ctrl_pkg::mem_type_t rd_type, wr_type;
    logic [31:0]               rd_addr, wr_addr;
    cache_types_pkg::line_t    wr_data;

    // row: op, cacheable, addr, wstrb, wdata, flags, expected, rd count, wr count
    logic [127:0] rows [NROWS];
    logic [127:0] row;
    logic [35:0]  pend [$];        // {flags, expected} per accepted request
    logic [35:0]  resp;
    logic [31:0]  mem [logic [29:0]];
    logic [31:0]  rd_lfsr, wr_lfsr, raddr, wtmp;
    logic [31:0]  acc_addr;        // latest accepted request, the one that can miss
    logic         acc_cacheable;
    logic         wr_ok;
    logic         stuck;
    int           nbeat, guard;
    int           rd_count, wr_count;
    int           data_errors, count_errors, req_errors, proto_errors;

    tb_clk_gen u_clk (.clk(clk), .resetn(resetn));

    cache_top dut (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32,22,2,1
    endfunction

    // unwritten words follow the address
    function automatic logic [31:0] mem_word(input logic [29:0] wa);
        if (mem.exists(wa)) begin
            return mem[wa];
        end
        return {2'b00, wa} ^ 32'hA5A5_5A5A;
    endfunction

    // cached accesses move whole lines, uncached ones a single word
    function automatic cache_ctrl_pkg::mem_type_t expected_type(input logic c);
        return c ? cache_ctrl_pkg::mem_line : cache_ctrl_pkg::mem_word;
    endfunction

    function automatic logic [31:0] expected_addr(input logic c, input logic [31:0] a);
        return c ? {a[31:4], 4'h0} : {a[31:2], 2'b00};
    endfunction

    task automatic check_counts(input int n, input logic [15:0] exp);
        assert (rd_count == int'(exp[15:8]) && wr_count == int'(exp[7:0])) else begin
            $display("CHECK FAILED at %0t ns: request %0d saw rd %0d wr %0d, expected %0d %0d",
                     $time, n, rd_count, wr_count, exp[15:8], exp[7:0]);
            count_errors++;
        end
    endtask

    task automatic finish_run();
        $display("errors: data %0d, request count %0d, memory request %0d, protocol %0d",
                 data_errors, count_errors, req_errors, proto_errors);
        if (data_errors + count_errors + req_errors + proto_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns: %s", $time, what);
        proto_errors++;
    endtask

    // memory read side, one optional gap cycle before each beat
    always begin
        @(negedge clk);
        if (rd_req && rd_rdy) begin
            raddr = rd_addr;
            nbeat = (rd_type == cache_ctrl_pkg::mem_line) ? 4 : 1;
            rd_count++;
            assert (rd_type === expected_type(acc_cacheable) &&
                    rd_addr === expected_addr(acc_cacheable, acc_addr)) else begin
                $display("CHECK FAILED at %0t ns: rd_req %0d %h, expected %0d %h",
                         $time, rd_type, rd_addr, expected_type(acc_cacheable),
                         expected_addr(acc_cacheable, acc_addr));
                req_errors++;
            end
            @(posedge clk);
            rd_rdy <= 1'b0;
            for (int i = 0; i < nbeat; i++) begin
                ret_valid <= 1'b0;
                rd_lfsr = lfsr_next(rd_lfsr);
                if (rd_lfsr[0]) begin
                    @(posedge clk);
                end
                ret_valid <= 1'b1;
                ret_last  <= (i == nbeat - 1);
                ret_data  <= mem_word(raddr[31:2] + 30'(i));
                @(posedge clk);
            end
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
        end else begin
            @(posedge clk);
            rd_lfsr = lfsr_next(rd_lfsr);
            rd_rdy <= rd_lfsr[0];
        end
    end

    // memory write side
    always begin
        @(negedge clk);
        if (wr_req) begin
            wr_count++;
            // a write-back goes to the victim's own line, so only its alignment is known
            wr_ok = (wr_type === expected_type(acc_cacheable)) &&
                    (acc_cacheable ? (wr_addr[3:0] === 4'h0)
                                   : (wr_addr === expected_addr(1'b0, acc_addr)));
            assert (wr_ok) else begin
                $display("CHECK FAILED at %0t ns: wr_req %0d %h, request at %h",
                         $time, wr_type, wr_addr, acc_addr);
                req_errors++;
            end
            if (wr_type == cache_ctrl_pkg::mem_line) begin
                for (int i = 0; i < 4; i++) begin
                    mem[wr_addr[31:2] + 30'(i)] = wr_data[32*i +: 32];
                end
            end else begin
                wtmp = mem_word(wr_addr[31:2]);
                for (int k = 0; k < 4; k++) begin
                    if (wr_wstrb[k]) begin
                        wtmp[8*k +: 8] = wr_data[8*k +: 8];
                    end
                end
                mem[wr_addr[31:2]] = wtmp;
            end
        end
        @(posedge clk);
        wr_lfsr = lfsr_next(wr_lfsr);
        wr_rdy <= wr_lfsr[0];
    end

    // responses come back in order
    always @(negedge clk) begin
        if (resetn && data_ok) begin
            assert (pend.size() != 0) else begin
                $display("data_ok at %0t ns with no request outstanding", $time);
                proto_errors++;
            end
            if (pend.size() != 0) begin
                resp = pend.pop_front();
                if (resp[32]) begin
                    assert (rdata === resp[31:0]) else begin
                        $display("CHECK FAILED at %0t ns: read data %h, expected %h",
                                 $time, rdata, resp[31:0]);
                        data_errors++;
                    end
                end
            end
        end
    end

    initial begin
        {valid, op, cacheable, index, tag, offset, wstrb, wdata} = '0;
        {rd_rdy, ret_valid, ret_last, ret_data, wr_rdy} = '0;
        rd_lfsr = 32'h563e_8323;
        wr_lfsr = 32'h563e_8323;
        acc_addr = '0;
        acc_cacheable = 1'b0;
        stuck = 1'b0;
        rd_count = 0;
        wr_count = 0;
        data_errors = 0;
        count_errors = 0;
        req_errors = 0;
        proto_errors = 0;
        $readmemh("verif/cache_testdata.txt", rows);
        guard = 0;
        while (!resetn && guard <= TIMEOUT) begin
            @(posedge clk);
            guard++;
        end
        if (!resetn) begin
            report_timeout("reset was never released");
            stuck = 1'b1;
        end
        for (int n = 0; n < NROWS && !stuck; n++) begin
            row = rows[n];
            @(posedge clk);
            valid     <= 1'b1;
            op        <= row[124];
            cacheable <= row[120];
            tag       <= row[119:100];
            index     <= row[99:92];
            offset    <= row[91:88];
            wstrb     <= row[87:84];
            wdata     <= row[83:52];
            guard = 0;
            do begin
                @(negedge clk);
                guard++;
            end while (!addr_ok && guard <= TIMEOUT);
            if (!addr_ok) begin
                report_timeout($sformatf("request %0d never saw addr_ok", n));
                stuck = 1'b1;
            end else begin
                acc_addr      = row[119:88];
                acc_cacheable = row[120];
                pend.push_back(row[51:16]);
                if (row[49]) begin   // drain before the next row
                    @(posedge clk);
                    valid <= 1'b0;
                    guard = 0;
                    do begin
                        @(negedge clk);
                        #1;
                        guard++;
                    end while ((pend.size() != 0 || !addr_ok) && guard <= TIMEOUT);
                    if (pend.size() != 0 || !addr_ok) begin
                        report_timeout($sformatf("request %0d never saw data_ok and idle", n));
                        stuck = 1'b1;
                    end else begin
                        check_counts(n, row[15:0]);
                    end
                end
            end
        end
        @(posedge clk);
        valid <= 1'b0;
        finish_run();
    end

endmodule

//--- verif/cache_testdata.txt
// op_cacheable_addr_wstrb_wdata_flags_expected_rdcount_wrcount
// flags bit0 check rdata, bit1 drain and check request counts
0_1_00001010_0_00000000_3_a5a55e5e_01_00
0_1_0000101c_0_00000000_3_a5a55e5d_01_00
1_1_00001014_1_000000cc_0_00000000_00_00
0_1_00001014_0_00000000_1_a5a55ecc_00_00
1_1_00001018_c_12340000_0_00000000_00_00
0_1_00001010_0_00000000_1_a5a55e5e_00_00
0_1_00001018_0_00000000_3_12345e5c_01_00
1_1_00002024_3_0000beef_2_00000000_02_00
0_1_00002024_0_00000000_1_a5a5beef_00_00
0_1_00002020_0_00000000_1_a5a55252_00_00
0_1_0000202c_0_00000000_3_a5a55251_02_00
1_1_00003030_f_deadbeef_2_00000000_03_00
0_1_00004030_0_00000000_3_a5a54a56_04_00
0_1_00005030_0_00000000_3_a5a54e56_05_01
0_1_00003030_0_00000000_3_deadbeef_06_01
0_0_00006040_0_00000000_3_a5a5424a_07_01
0_0_00006040_0_00000000_3_a5a5424a_08_01
1_0_00006040_3_00001111_2_00000000_08_02
0_0_00006040_0_00000000_3_a5a51111_09_02

//--- files.f
+incdir+rtl
rtl/cache_types_pkg.sv
rtl/cache_ctrl_pkg.sv
rtl/sram_sp.sv
rtl/cache_ram_if.sv
rtl/cache_store.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
verif/tb_clk_gen.sv
verif/cache_tb.sv

//--- Makefile
TOP = cache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing -f files.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
